// File: src/tenyr_cfg.svh
`ifndef TENYR_CFG_SVH
`define TENYR_CFG_SVH

// Word address into either memory
`define TENYR_ADDR_W 10

// Words held by each memory, matches the address width
`define TENYR_MEM_DEPTH 1024

// First fetch address after reset
`define TENYR_RESET_VECTOR 0

`endif

// File: src/tenyr_pkg.sv
`include "tenyr_cfg.svh"

package tenyr_pkg;

    // Opcode field, bits 15:12 of the instruction
    typedef enum logic [3:0] {
        OP_OR      = 4'h0,
        OP_AND     = 4'h1,
        OP_ADD     = 4'h2,
        OP_MUL     = 4'h3,
        OP_RSVD    = 4'h4, // Halts the core
        OP_SHL     = 4'h5,
        OP_CMP_LE  = 4'h6,
        OP_CMP_EQ  = 4'h7,
        OP_NOR     = 4'h8,
        OP_NAND    = 4'h9,
        OP_XOR     = 4'ha,
        OP_SUB     = 4'hb,
        OP_XORN    = 4'hc,
        OP_SHR     = 4'hd,
        OP_CMP_GT  = 4'he,
        OP_CMP_NE  = 4'hf
    } alu_op_e;

    // Bit 1 set means a memory write, bit 0 set means rhs is the address
    // for a load or a store of Z
    typedef enum logic [1:0] {
        DEREF_REG_FROM_RHS   = 2'b00, // Z <- rhs
        DEREF_REG_FROM_MEM   = 2'b01, // Z <- [rhs]
        DEREF_MEM_Z_FROM_RHS = 2'b10, // [Z] <- rhs
        DEREF_MEM_RHS_FROM_Z = 2'b11  // [rhs] <- Z
    } deref_e;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_COMMIT,
        ST_HALTED
    } core_state_e;

    typedef struct packed {
        logic [3:0]  z;
        logic [3:0]  x;
        logic [3:0]  y;
        alu_op_e     op;
        logic [11:0] imm;
        logic        type_b; // 1 swaps the roles of Y and the immediate
        deref_e      deref;
        logic        illegal;
    } insn_fields_t;

    typedef struct packed {
        logic [`TENYR_ADDR_W-1:0] addr;
        logic [31:0]              data;
    } mem_store_t;

endpackage

// File: src/tenyr_decode.sv
`timescale 1ns/1ps

module tenyr_decode
    import tenyr_pkg::*;
(
    input  logic [31:0]  i_insn,
    output insn_fields_t o_fields
);

    logic top_ones;
    logic top_set;

    assign top_ones = &i_insn[31:28];
    assign top_set  = i_insn[31];

    always_comb begin
        // All-zero fields write zero into A, which is a no-op
        o_fields = '0;

        if (top_ones) begin
            o_fields.illegal = 1'b1;
        end else if (!top_set) begin
            o_fields.type_b  = i_insn[30];
            o_fields.deref   = deref_e'(i_insn[29:28]);
            o_fields.z       = i_insn[27:24];
            o_fields.x       = i_insn[23:20];
            o_fields.y       = i_insn[19:16];
            o_fields.op      = alu_op_e'(i_insn[15:12]);
            o_fields.imm     = i_insn[11:0];
            o_fields.illegal = (i_insn[15:12] == OP_RSVD);
        end
        // Other words with bit 31 set keep the no-op default
    end

endmodule

// File: src/tenyr_alu.sv
`timescale 1ns/1ps

module tenyr_alu
    import tenyr_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  logic         i_start,
    input  insn_fields_t i_fields,
    input  logic [31:0]  i_x,
    input  logic [31:0]  i_y,
    output logic [31:0]  o_rhs
);

    logic [31:0] imm_ext;
    logic [31:0] operand; // Right-hand operand of op
    logic [31:0] addend;
    logic [31:0] op_result;
    logic [31:0] rhs_next;

    assign imm_ext = {{20{i_fields.imm[11]}}, i_fields.imm};

    // Type 0 is (X op Y) + I and type 1 is (X op I) + Y
    assign operand = i_fields.type_b ? imm_ext : i_y;
    assign addend  = i_fields.type_b ? i_y : imm_ext;

    always_comb begin
        case (i_fields.op)
            OP_OR:     op_result = i_x | operand;
            OP_AND:    op_result = i_x & operand;
            OP_ADD:    op_result = i_x + operand;
            OP_MUL:    op_result = i_x * operand;
            OP_SHL:    op_result = i_x << operand;
            OP_CMP_LE: op_result = {32{$signed(i_x) <= $signed(operand)}};
            OP_CMP_EQ: op_result = {32{i_x == operand}};
            OP_NOR:    op_result = ~(i_x | operand);
            OP_NAND:   op_result = ~(i_x & operand);
            OP_XOR:    op_result = i_x ^ operand;
            OP_SUB:    op_result = i_x - operand;
            OP_XORN:   op_result = i_x ^ ~operand;
            OP_SHR:    op_result = i_x >> operand; // Logical shift
            OP_CMP_GT: op_result = {32{$signed(i_x) > $signed(operand)}};
            OP_CMP_NE: op_result = {32{i_x != operand}};
            default:   op_result = '0; // Reserved op halts in exec
        endcase
    end

    assign rhs_next = op_result + addend;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            o_rhs <= '0;
        end else if (i_start) begin
            o_rhs <= rhs_next;
        end
    end

endmodule

// File: src/tenyr_regfile.sv
`timescale 1ns/1ps

module tenyr_regfile (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [31:0] i_pc,
    input  logic [3:0]  i_idx_x,
    input  logic [3:0]  i_idx_y,
    input  logic [3:0]  i_idx_z,
    input  logic        i_wr_valid,
    input  logic [31:0] i_wr_data,
    output logic [31:0] o_x,
    output logic [31:0] o_y,
    output logic [31:0] o_z
);

    logic [31:0] regs [1:14]; // B through O

    // A reads as zero, P comes from the core
    function automatic logic [31:0] read_reg(input logic [3:0] idx);
        logic [31:0] value;
        if (idx == 4'd0) begin
            value = '0;
        end else if (idx == 4'd15) begin
            value = i_pc;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    assign o_x = read_reg(i_idx_x);
    assign o_y = read_reg(i_idx_y);
    assign o_z = read_reg(i_idx_z);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 1; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_valid && i_idx_z != 4'd0 && i_idx_z != 4'd15) begin
            regs[i_idx_z] <= i_wr_data;
        end
    end

endmodule

// File: src/tenyr_mem.sv
`timescale 1ns/1ps
`include "tenyr_cfg.svh"

module tenyr_mem
    import tenyr_pkg::*;
(
    input  logic                     clk,
    input  logic [`TENYR_ADDR_W-1:0] i_addr,
    input  logic                     i_wr_valid,
    input  mem_store_t               i_wr,
    input  logic                     i_load_valid,
    input  mem_store_t               i_load,
    output logic [31:0]              o_rdata
);

    logic [31:0] mem [0:`TENYR_MEM_DEPTH-1];

    assign o_rdata = mem[i_addr]; // Combinational read

    always_ff @(posedge clk) begin
        if (i_load_valid) begin
            mem[i_load.addr] <= i_load.data; // Loader wins a collision
        end else if (i_wr_valid) begin
            mem[i_wr.addr] <= i_wr.data;
        end
    end

endmodule

// File: src/tenyr_core.sv
`timescale 1ns/1ps
`include "tenyr_cfg.svh"

module tenyr_core
    import tenyr_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     i_run,
    input  logic [31:0]              i_imem_rdata,
    input  logic [31:0]              i_dmem_rdata,
    output logic [`TENYR_ADDR_W-1:0] o_imem_addr,
    output logic [`TENYR_ADDR_W-1:0] o_dmem_addr,
    output logic                     o_dmem_wr_valid,
    output mem_store_t               o_dmem_wr,
    output logic                     o_halt
);

    core_state_e  state_q;
    logic [31:0]  pc_q;
    insn_fields_t dec_fields;
    insn_fields_t fields_q;
    logic [31:0]  val_x;
    logic [31:0]  val_y;
    logic [31:0]  val_z;
    logic [31:0]  rhs;
    logic         commit;
    logic         reg_wr;
    logic [31:0]  reg_wr_data;
    logic         jump;
    logic [31:0]  mem_addr;

    tenyr_decode u_decode (
        .i_insn   (i_imem_rdata),
        .o_fields (dec_fields)
    );

    tenyr_regfile u_regfile (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_pc       (pc_q),
        .i_idx_x    (fields_q.x),
        .i_idx_y    (fields_q.y),
        .i_idx_z    (fields_q.z),
        .i_wr_valid (reg_wr),
        .i_wr_data  (reg_wr_data),
        .o_x        (val_x),
        .o_y        (val_y),
        .o_z        (val_z)
    );

    tenyr_alu u_alu (
        .clk      (clk),
        .reset_n  (reset_n),
        .i_start  (state_q == ST_EXEC),
        .i_fields (fields_q),
        .i_x      (val_x),
        .i_y      (val_y),
        .o_rhs    (rhs)
    );

    assign commit = (state_q == ST_COMMIT);

    // Modes 00 and 01 write Z, modes 10 and 11 write memory
    assign reg_wr      = commit && !fields_q.deref[1];
    assign reg_wr_data = fields_q.deref[0] ? i_dmem_rdata : rhs;
    assign jump        = reg_wr && (fields_q.z == 4'd15);

    // Only a store to [Z] addresses memory with Z
    assign mem_addr    = (fields_q.deref == DEREF_MEM_Z_FROM_RHS) ? val_z : rhs;
    assign o_dmem_addr = mem_addr[`TENYR_ADDR_W-1:0];

    assign o_dmem_wr_valid = commit && fields_q.deref[1];
    assign o_dmem_wr.addr  = mem_addr[`TENYR_ADDR_W-1:0];
    assign o_dmem_wr.data  = fields_q.deref[0] ? val_z : rhs;

    assign o_imem_addr = pc_q[`TENYR_ADDR_W-1:0];
    assign o_halt      = (state_q == ST_HALTED); // Left only by reset

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state_q <= ST_FETCH;
            pc_q    <= 32'(`TENYR_RESET_VECTOR);
        end else begin
            case (state_q)
                ST_FETCH: begin
                    if (i_run) begin
                        state_q <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    state_q <= fields_q.illegal ? ST_HALTED : ST_COMMIT;
                end
                ST_COMMIT: begin
                    pc_q    <= jump ? reg_wr_data : pc_q + 32'd1;
                    state_q <= ST_FETCH;
                end
                default: state_q <= ST_HALTED;
            endcase
        end
    end

    // Instruction latch for exec and commit
    always_ff @(posedge clk) begin
        if (state_q == ST_FETCH && i_run) begin
            fields_q <= dec_fields;
        end
    end

endmodule

// File: src/tenyr_top.sv
`timescale 1ns/1ps
`include "tenyr_cfg.svh"

module tenyr_top
    import tenyr_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       i_run,
    input  logic       i_load_valid,
    input  logic       i_load_sel,   // 0 instructions, 1 data
    input  mem_store_t i_load,
    output logic       o_store_valid,
    output mem_store_t o_store,
    output logic       o_halt
);

    logic [`TENYR_ADDR_W-1:0] imem_addr;
    logic [`TENYR_ADDR_W-1:0] dmem_addr;
    logic [31:0]              imem_rdata;
    logic [31:0]              dmem_rdata;

    tenyr_core u_core (
        .clk             (clk),
        .reset_n         (reset_n),
        .i_run           (i_run),
        .i_imem_rdata    (imem_rdata),
        .i_dmem_rdata    (dmem_rdata),
        .o_imem_addr     (imem_addr),
        .o_dmem_addr     (dmem_addr),
        .o_dmem_wr_valid (o_store_valid),
        .o_dmem_wr       (o_store),
        .o_halt          (o_halt)
    );

    // Instruction memory is written only by the loader
    tenyr_mem u_imem (
        .clk          (clk),
        .i_addr       (imem_addr),
        .i_wr_valid   (1'b0),
        .i_wr         ('0),
        .i_load_valid (i_load_valid && !i_load_sel),
        .i_load       (i_load),
        .o_rdata      (imem_rdata)
    );

    tenyr_mem u_dmem (
        .clk          (clk),
        .i_addr       (dmem_addr),
        .i_wr_valid   (o_store_valid),
        .i_wr         (o_store),
        .i_load_valid (i_load_valid && i_load_sel),
        .i_load       (i_load),
        .o_rdata      (dmem_rdata)
    );

endmodule

// File: verification/tenyr_assert.sv
`timescale 1ns/1ps

module tenyr_assert
    import tenyr_pkg::*;
(
    input logic        clk,
    input logic        reset_n,
    input core_state_e i_state,
    input logic        i_store_valid,
    input logic        i_reg_wr,
    input logic        i_halt
);

    state_legal: assert property (@(posedge clk) disable iff (reset_n)
        !$isunknown(i_state) && (i_state inside {ST_FETCH, ST_EXEC, ST_COMMIT, ST_HALTED}))
        else $error("core state is unknown or outside the sequencer states");

    // A store belongs to the commit that directly follows exec
    store_in_commit: assert property (@(posedge clk) disable iff (reset_n)
        i_store_valid |-> i_state == ST_COMMIT && $past(i_state) == ST_EXEC)
        else $error("store strobe seen outside the commit state");

    // Only reset may clear the halt
    halt_sticky: assert property (@(posedge clk) disable iff (reset_n)
        i_halt |=> i_halt)
        else $error("halt fell without a reset");

    halted_quiet: assert property (@(posedge clk) disable iff (reset_n)
        i_state == ST_HALTED |-> !i_store_valid && !i_reg_wr)
        else $error("write issued while the core is halted");

endmodule

bind tenyr_core tenyr_assert u_assert (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_state       (state_q),
    .i_store_valid (o_dmem_wr_valid),
    .i_reg_wr      (reg_wr),
    .i_halt        (o_halt)
);

// File: verification/tb_tenyr.sv
`timescale 1ns/1ps
`include "tenyr_cfg.svh"

module tb_tenyr
    import tenyr_pkg::*;
();

    localparam logic [3:0]  reg_a = 4'd0;
    localparam logic [3:0]  reg_b = 4'd1;
    localparam logic [3:0]  reg_c = 4'd2;
    localparam logic [3:0]  reg_d = 4'd3;
    localparam logic [3:0]  reg_p = 4'd15;
    localparam logic [31:0] halt_word = 32'hf000_0000; // Top nibble all ones

    // Cycle budget from program length, loader writes and per-run overhead
    localparam int insn_total      = 149;
    localparam int load_total      = 210;
    localparam int run_count       = 7;
    localparam int watchdog_cycles = 3 * insn_total + load_total + 20 * run_count + 100;

    logic       clk;
    logic       reset_n;
    logic       run;
    logic       load_valid;
    logic       load_sel;
    mem_store_t load_bus;
    logic       store_valid;
    mem_store_t store_out;
    logic       halt;

    logic [31:0] prog[$];
    mem_store_t  preload[$];
    mem_store_t  expect_q[$];
    mem_store_t  seen_stores[$];
    int          seen_cycles[$];
    int          cycle_count = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    logic [31:0] lfsr_state = 32'h658115b2;

    tenyr_top i_dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_run         (run),
        .i_load_valid  (load_valid),
        .i_load_sel    (load_sel),
        .i_load        (load_bus),
        .o_store_valid (store_valid),
        .o_store       (store_out),
        .o_halt        (halt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // Store outputs come from registers only, so the falling edge is quiet
    always @(negedge clk) begin
        if (store_valid === 1'b1) begin
            seen_stores.push_back(store_out);
            seen_cycles.push_back(cycle_count);
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run is stuck", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic feedback;
        feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], feedback};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] encode(input logic type_b, input deref_e deref,
                                           input logic [3:0] z, input logic [3:0] x,
                                           input logic [3:0] y, input alu_op_e op,
                                           input logic [11:0] imm);
        return {1'b0, type_b, deref, z, x, y, op, imm};
    endfunction

    function automatic logic [31:0] apply_op(input alu_op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [31:0] r;
        case (op)
            OP_OR:     r = a | b;
            OP_AND:    r = a & b;
            OP_ADD:    r = a + b;
            OP_MUL:    r = a * b;
            OP_SHL:    r = (b > 32'd31) ? 32'd0 : (a << b[4:0]);
            OP_CMP_LE: r = ($signed(a) <= $signed(b)) ? 32'hffff_ffff : 32'd0;
            OP_CMP_EQ: r = (a == b) ? 32'hffff_ffff : 32'd0;
            OP_NOR:    r = ~(a | b);
            OP_NAND:   r = ~(a & b);
            OP_XOR:    r = a ^ b;
            OP_SUB:    r = a - b;
            OP_XORN:   r = a ^ ~b;
            OP_SHR:    r = (b > 32'd31) ? 32'd0 : (a >> b[4:0]);
            OP_CMP_GT: r = ($signed(a) > $signed(b)) ? 32'hffff_ffff : 32'd0;
            OP_CMP_NE: r = (a != b) ? 32'hffff_ffff : 32'd0;
            default:   r = 32'd0;
        endcase
        return r;
    endfunction

    // Type 0 is (X op Y) + I, type 1 is (X op I) + Y
    function automatic logic [31:0] rule_value(input alu_op_e op, input logic type_b,
                                               input logic [31:0] x, input logic [31:0] y,
                                               input logic [11:0] imm);
        logic [31:0] imm_s;
        imm_s = {{20{imm[11]}}, imm};
        return type_b ? apply_op(op, x, imm_s) + y : apply_op(op, x, y) + imm_s;
    endfunction

    task automatic check_store(input int index, input mem_store_t got, input mem_store_t exp);
        if (got.addr !== exp.addr) begin
            $display("[FAIL] %0t o_store[%0d].addr got %h expected %h",
                     $time, index, got.addr, exp.addr);
            value_errors++;
        end
        if (got.data !== exp.data) begin
            $display("[FAIL] %0t o_store[%0d].data got %h expected %h",
                     $time, index, got.data, exp.data);
            value_errors++;
        end
    endtask

    task automatic check_halt(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t o_halt got %b expected %b", $time, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_gap(input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %0t o_store_valid spacing got %0d expected %0d", $time, got, exp);
            value_errors++;
        end
    endtask

    task automatic begin_program();
        prog.delete();
        preload.delete();
        expect_q.delete();
    endtask

    task automatic preload_word(input int addr, input logic [31:0] data);
        mem_store_t s;
        s.addr = `TENYR_ADDR_W'(addr);
        s.data = data;
        preload.push_back(s);
    endtask

    task automatic expect_store(input int addr, input logic [31:0] data);
        mem_store_t s;
        s.addr = `TENYR_ADDR_W'(addr);
        s.data = data;
        expect_q.push_back(s);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_n = 1'b1;
        repeat (5) @(negedge clk);
        reset_n = 1'b0;
    endtask

    // Load both memories with the core stopped, reset, run until halt
    task automatic run_program();
        int waited;
        run = 1'b0;
        foreach (prog[i]) begin
            @(negedge clk);
            load_valid    = 1'b1;
            load_sel      = 1'b0;
            load_bus.addr = `TENYR_ADDR_W'(i);
            load_bus.data = prog[i];
        end
        foreach (preload[i]) begin
            @(negedge clk);
            load_valid = 1'b1;
            load_sel   = 1'b1;
            load_bus   = preload[i];
        end
        @(negedge clk);
        load_valid = 1'b0;
        apply_reset();
        check_halt(halt, 1'b0);
        seen_stores.delete();
        seen_cycles.delete();
        run = 1'b1;
        waited = 0;
        while (halt !== 1'b1 && waited < 3 * prog.size() + 10) begin
            @(negedge clk);
            waited++;
        end
        if (halt !== 1'b1) begin
            $display("Core did not halt within %0d cycles at %0t", waited, $time);
            other_errors++;
        end
    endtask

    task automatic compare_stores();
        if (seen_stores.size() != expect_q.size()) begin
            $display("Saw %0d stores where %0d were expected at %0t",
                     seen_stores.size(), expect_q.size(), $time);
            other_errors++;
        end
        for (int i = 0; i < expect_q.size() && i < seen_stores.size(); i++) begin
            check_store(i, seen_stores[i], expect_q[i]);
        end
    endtask

    task automatic test_opcodes();
        logic [31:0] x_val;
        logic [31:0] y_val;
        logic [31:0] imm_bits;
        logic [3:0]  y_idx;
        alu_op_e     op;
        int          k;
        begin_program();
        k = 0;
        for (int t = 0; t < 2; t++) begin
            for (int o = 0; o < 16; o++) begin
                op = alu_op_e'(o[3:0]);
                if (op != OP_RSVD) begin
                    take_bits(32, x_val);
                    take_bits((op == OP_SHL || op == OP_SHR) ? 5 : 32, y_val);
                    take_bits((op == OP_SHL || op == OP_SHR) ? 5 : 12, imm_bits);
                    // Equal operands for one compare of each kind
                    y_idx = ((op == OP_CMP_EQ || op == OP_CMP_NE) && t == 0) ? reg_b : reg_c;
                    preload_word(16 + 2 * k, x_val);
                    preload_word(17 + 2 * k, y_val);
                    prog.push_back(encode(1'b0, DEREF_REG_FROM_MEM, reg_b, reg_a, reg_a,
                                          OP_OR, 12'(16 + 2 * k)));
                    prog.push_back(encode(1'b0, DEREF_REG_FROM_MEM, reg_c, reg_a, reg_a,
                                          OP_OR, 12'(17 + 2 * k)));
                    prog.push_back(encode(t[0], DEREF_REG_FROM_RHS, reg_d, reg_b, y_idx,
                                          op, imm_bits[11:0]));
                    prog.push_back(encode(1'b0, DEREF_MEM_Z_FROM_RHS, reg_a, reg_d, reg_a,
                                          OP_OR, 12'd0));
                    expect_store(0, rule_value(op, t[0], x_val,
                                               (y_idx == reg_b) ? x_val : y_val,
                                               imm_bits[11:0]));
                    k++;
                end
            end
        end
        prog.push_back(halt_word);
        run_program();
        compare_stores();
    endtask

    task automatic test_loads();
        logic [31:0] word;
        begin_program();
        take_bits(32, word);
        preload_word(100, word);
        prog.push_back(encode(1'b0, DEREF_REG_FROM_MEM, reg_b, reg_a, reg_a, OP_OR, 12'd100));
        prog.push_back(encode(1'b0, DEREF_REG_FROM_RHS, reg_c, reg_a, reg_a, OP_OR, 12'd7));
        prog.push_back(encode(1'b0, DEREF_MEM_Z_FROM_RHS, reg_a, reg_b, reg_a, OP_OR, 12'd0));
        prog.push_back(encode(1'b0, DEREF_MEM_RHS_FROM_Z, reg_b, reg_c, reg_a, OP_ADD, 12'd50));
        prog.push_back(encode(1'b0, DEREF_REG_FROM_MEM, reg_d, reg_a, reg_a, OP_OR, 12'd57));
        prog.push_back(encode(1'b0, DEREF_MEM_Z_FROM_RHS, reg_a, reg_d, reg_a, OP_OR, 12'd0));
        prog.push_back(halt_word);
        expect_store(0, word);
        expect_store(57, word);  // 7 + 50
        expect_store(0, word);   // Read back from 57
        run_program();
        compare_stores();
    endtask

    task automatic test_reg_a();
        begin_program();
        prog.push_back(encode(1'b0, DEREF_REG_FROM_RHS, reg_a, reg_a, reg_a, OP_OR, 12'h123));
        prog.push_back(encode(1'b0, DEREF_MEM_Z_FROM_RHS, reg_a, reg_a, reg_a, OP_OR, 12'd0));
        prog.push_back(encode(1'b0, DEREF_MEM_RHS_FROM_Z, reg_a, reg_a, reg_a, OP_OR, 12'd5));
        prog.push_back(halt_word);
        expect_store(0, 32'd0);
        expect_store(5, 32'd0);
        run_program();
        compare_stores();
    endtask

    task automatic test_jump();
        begin_program();
        prog.push_back(encode(1'b0, DEREF_MEM_Z_FROM_RHS, reg_a, reg_a, reg_a, OP_OR, 12'h011));
        prog.push_back(encode(1'b0, DEREF_REG_FROM_RHS, reg_p, reg_p, reg_a, OP_OR, 12'd2));
        prog.push_back(encode(1'b0, DEREF_MEM_Z_FROM_RHS, reg_a, reg_a, reg_a, OP_OR, 12'h022));
        prog.push_back(encode(1'b0, DEREF_MEM_Z_FROM_RHS, reg_a, reg_p, reg_a, OP_OR, 12'd0));
        prog.push_back(halt_word);
        expect_store(0, 32'h11);
        expect_store(0, 32'd3); // P reads as its own address
        run_program();
        compare_stores();
    endtask

    task automatic test_halt();
        begin_program();
        prog.push_back(32'ha000_0abc); // Would store to [A] if bit 31 did not make it a no-op
        prog.push_back(encode(1'b0, DEREF_MEM_Z_FROM_RHS, reg_a, reg_a, reg_a, OP_OR, 12'h055));
        prog.push_back(32'hf123_4567);
        prog.push_back(encode(1'b0, DEREF_MEM_Z_FROM_RHS, reg_a, reg_a, reg_a, OP_OR, 12'h066));
        expect_store(0, 32'h55);
        run_program();
        repeat (10) @(negedge clk);
        check_halt(halt, 1'b1);
        compare_stores();

        begin_program();
        prog.push_back(encode(1'b0, DEREF_MEM_Z_FROM_RHS, reg_a, reg_a, reg_a, OP_OR, 12'h077));
        prog.push_back(encode(1'b0, DEREF_MEM_Z_FROM_RHS, reg_a, reg_a, reg_a, OP_RSVD, 12'h088));
        prog.push_back(encode(1'b0, DEREF_MEM_Z_FROM_RHS, reg_a, reg_a, reg_a, OP_OR, 12'h099));
        expect_store(0, 32'h77);
        run_program();
        repeat (10) @(negedge clk);
        check_halt(halt, 1'b1);
        compare_stores();
    endtask

    task automatic test_store_timing();
        begin_program();
        for (int k = 1; k <= 4; k++) begin
            prog.push_back(encode(1'b0, DEREF_MEM_Z_FROM_RHS, reg_a, reg_a, reg_a, OP_OR,
                                  12'(k)));
            expect_store(0, 32'(k));
        end
        prog.push_back(halt_word);
        run_program();
        compare_stores();
        for (int i = 1; i < seen_cycles.size(); i++) begin
            check_gap(seen_cycles[i] - seen_cycles[i - 1], 3);
        end
    endtask

    initial begin
        reset_n    = 1'b1;
        run        = 1'b0;
        load_valid = 1'b0;
        load_sel   = 1'b0;
        load_bus   = '0;
        repeat (5) @(negedge clk);
        reset_n = 1'b0;

        test_opcodes();
        test_loads();
        test_reg_a();
        test_jump();
        test_halt();
        test_store_timing();

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+src
src/tenyr_pkg.sv
src/tenyr_decode.sv
src/tenyr_alu.sv
src/tenyr_regfile.sv
src/tenyr_mem.sv
src/tenyr_core.sv
src/tenyr_top.sv
verification/tenyr_assert.sv
verification/tb_tenyr.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module tb_tenyr -o tb_tenyr_sim &&
./obj_dir/tb_tenyr_sim | tee /dev/stderr | grep "TEST PASSED" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
